//--- verilog/ppu_reg_pkg.sv
// register map for the background-only picture unit with no sprite, window, DMA or OBP registers
package ppu_reg_pkg;

    // memory-mapped register addresses
    localparam logic [15:0] REG_LCDC = 16'hff40;
    localparam logic [15:0] REG_STAT = 16'hff41;
    localparam logic [15:0] REG_SCY  = 16'hff42;
    localparam logic [15:0] REG_SCX  = 16'hff43;
    localparam logic [15:0] REG_LY   = 16'hff44;   // read only
    localparam logic [15:0] REG_LYC  = 16'hff45;
    localparam logic [15:0] REG_BGP  = 16'hff47;

    localparam logic [7:0] MMIO_UNMAPPED = 8'hff;

    localparam int LCDC_ON       = 7;
    localparam int LCDC_TILE_SEL = 4;   // 1 selects unsigned tile numbers at 8000
    localparam int LCDC_MAP_SEL  = 3;
    localparam int LCDC_BG_EN    = 0;

    localparam int STAT_LYC_FLAG  = 2;
    localparam int STAT_IE_HBLANK = 3;
    localparam int STAT_IE_VBLANK = 4;
    localparam int STAT_IE_SCAN   = 5;
    localparam int STAT_IE_LYC    = 6;

    typedef enum logic [1:0] {MODE_HBLANK = 2'd0, MODE_VBLANK = 2'd1, MODE_SCAN = 2'd2,
                              MODE_DRAW = 2'd3} ppu_mode_t;

endpackage

//--- verilog/ppu_fetch_pkg.sv
// VRAM layout and line timing assume one dot per clk and a draw phase of variable length
package ppu_fetch_pkg;

    typedef logic [15:0] vram_addr_t;
    typedef logic [1:0]  pixel_t;       // 0 is the lightest shade

    // background tile maps and tile data
    localparam vram_addr_t MAP0_BASE          = 16'h9800;
    localparam vram_addr_t MAP1_BASE          = 16'h9c00;
    localparam vram_addr_t TILE_BASE_UNSIGNED = 16'h8000;
    localparam vram_addr_t TILE_BASE_SIGNED   = 16'h9000;   // tile 0 sits in the middle
    localparam vram_addr_t TILE_BYTES         = 16'd16;
    localparam vram_addr_t MAP_ROW_TILES      = 16'd32;

    // screen geometry
    localparam logic [7:0] SCREEN_W     = 8'd160;
    localparam logic [7:0] SCREEN_LINES = 8'd144;
    localparam logic [7:0] LAST_LINE    = 8'd153;

    // dot counts within one line
    localparam logic [10:0] SCAN_DOTS = 11'd80;
    localparam logic [10:0] LINE_DOTS = 11'd456;

    // one extra tile covers the fine-scroll overhang
    localparam logic [4:0] FETCH_TILES = 5'd21;

    typedef enum logic [2:0] {FETCH_IDLE, FETCH_MAP, FETCH_LO, FETCH_HI,
                              FETCH_PUSH} fetch_state_t;

endpackage

//--- verilog/ppu_if.sv
// configuration is sampled live by every block and rows move on a valid/ready handshake
`timescale 1ns/10ps

interface ppu_cfg_if
    import ppu_reg_pkg::*;
();
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] bgp;
    logic [7:0] ly;
    ppu_mode_t  mode;

    modport reg_mp   (output lcdc, scx, scy, bgp, input ly, mode);
    modport timer_mp (input lcdc, output ly, mode);
    modport fetch_mp (input lcdc, scx, scy, ly, mode);
    modport pix_mp   (input lcdc, scx, bgp);

endinterface

interface ppu_row_if ();
    logic       valid;
    logic       ready;      // high only while the shifter is empty
    logic [7:0] tile_lo;    // bit 7 is the leftmost pixel
    logic [7:0] tile_hi;
    logic       line_done;  // one-cycle pulse on the last visible pixel

    modport fetch_mp (output valid, tile_lo, tile_hi, input ready, line_done);
    modport pix_mp   (input valid, tile_lo, tile_hi, output ready, line_done);

endinterface

//--- verilog/ppu_reg_decode.sv
// no read and write in one cycle, rdata is zero while mmio_rd is low, LY writes are dropped
`timescale 1ns/10ps

module ppu_reg_decode
    import ppu_reg_pkg::*, ppu_fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vram_addr_t mmio_addr,
    input  logic       mmio_wr,
    input  logic       mmio_rd,
    input  logic [7:0] mmio_wdata,
    output logic [7:0] mmio_rdata,
    output logic       irq_vblank,
    output logic       irq_stat,
    ppu_cfg_if.reg_mp  cfg
);

    logic [7:0] lyc;
    logic [6:3] stat_ie;    // indexed by the STAT bit positions
    logic       lyc_flag;
    logic [7:0] stat_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.lcdc <= '0;
            cfg.scy  <= '0;
            cfg.scx  <= '0;
            cfg.bgp  <= '0;
            lyc      <= '0;
            stat_ie  <= '0;
        end else if (mmio_wr) begin
            case (mmio_addr)
                REG_LCDC: cfg.lcdc <= mmio_wdata;
                REG_STAT: stat_ie  <= mmio_wdata[STAT_IE_LYC:STAT_IE_HBLANK];
                REG_SCY:  cfg.scy  <= mmio_wdata;
                REG_SCX:  cfg.scx  <= mmio_wdata;
                REG_LYC:  lyc      <= mmio_wdata;
                REG_BGP:  cfg.bgp  <= mmio_wdata;
                default: ;          // LY and unmapped addresses
            endcase
        end
    end

    assign lyc_flag = (cfg.ly == lyc);
    assign stat_rd  = {1'b1, stat_ie, lyc_flag, cfg.mode};   // bit 7 always reads 1

    always_comb begin
        mmio_rdata = 8'h00;
        if (mmio_rd) begin
            case (mmio_addr)
                REG_LCDC: mmio_rdata = cfg.lcdc;
                REG_STAT: mmio_rdata = stat_rd;
                REG_SCY:  mmio_rdata = cfg.scy;
                REG_SCX:  mmio_rdata = cfg.scx;
                REG_LY:   mmio_rdata = cfg.ly;
                REG_LYC:  mmio_rdata = lyc;
                REG_BGP:  mmio_rdata = cfg.bgp;
                default:  mmio_rdata = MMIO_UNMAPPED;
            endcase
        end
    end

    assign irq_vblank = (cfg.mode == MODE_VBLANK);
    assign irq_stat   = (stat_ie[STAT_IE_HBLANK] && cfg.mode == MODE_HBLANK)
                     || (stat_ie[STAT_IE_VBLANK] && cfg.mode == MODE_VBLANK)
                     || (stat_ie[STAT_IE_SCAN]   && cfg.mode == MODE_SCAN)
                     || (stat_ie[STAT_IE_LYC]    && stat_rd[STAT_LYC_FLAG]);

    host_excl: assert property (@(posedge clk) disable iff (rst) !(mmio_wr && mmio_rd));

endmodule

//--- verilog/ppu_line_timer.sv
// a visible line lasts at least 456 dots and stretches when draw is held up by back-pressure
`timescale 1ns/10ps

module ppu_line_timer
    import ppu_reg_pkg::*, ppu_fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    ppu_cfg_if.timer_mp  cfg,
    input  logic         line_done
);

    logic [10:0] dot;       // saturates on very long lines
    logic        running;

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcdc[LCDC_ON]) begin
            dot      <= '0;
            running  <= 1'b0;
            cfg.ly   <= '0;
            cfg.mode <= MODE_HBLANK;
        end else if (!running) begin
            running  <= 1'b1;                   // line 0 dot 0
            cfg.mode <= MODE_SCAN;
        end else begin
            if (dot != '1) begin
                dot <= dot + 11'd1;
            end
            case (cfg.mode)
                MODE_SCAN: begin
                    if (dot == SCAN_DOTS - 11'd1) begin
                        cfg.mode <= MODE_DRAW;
                    end
                end
                MODE_DRAW: begin
                    if (line_done) begin
                        cfg.mode <= MODE_HBLANK;
                    end
                end
                MODE_HBLANK: begin
                    if (dot >= LINE_DOTS - 11'd1) begin     // late draw leaves one cycle here
                        dot      <= '0;
                        cfg.ly   <= cfg.ly + 8'd1;
                        cfg.mode <= (cfg.ly == SCREEN_LINES - 8'd1) ? MODE_VBLANK : MODE_SCAN;
                    end
                end
                default: begin                              // V-blank lines are fixed length
                    if (dot == LINE_DOTS - 11'd1) begin
                        dot <= '0;
                        if (cfg.ly == LAST_LINE) begin
                            cfg.ly   <= '0;
                            cfg.mode <= MODE_SCAN;
                        end else begin
                            cfg.ly <= cfg.ly + 8'd1;
                        end
                    end
                end
            endcase
        end
    end

    ly_range: assert property (@(posedge clk) disable iff (rst) cfg.ly <= LAST_LINE);

    draw_visible: assert property (@(posedge clk) disable iff (rst)
        (cfg.mode != MODE_DRAW) ##1 (cfg.mode == MODE_DRAW) |-> cfg.ly < SCREEN_LINES);

endmodule

//--- verilog/ppu_bg_fetch.sv
// one VRAM read outstanding at most and a request stalled at line end still completes
`timescale 1ns/10ps

module ppu_bg_fetch
    import ppu_reg_pkg::*, ppu_fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    ppu_cfg_if.fetch_mp  cfg,
    output logic         vram_req_valid,
    output vram_addr_t   vram_addr,
    input  logic         vram_req_ready,
    input  logic         vram_rdata_valid,
    input  logic [7:0]   vram_rdata,
    ppu_row_if.fetch_mp  row
);

    fetch_state_t state;
    logic         wait_rsp;     // request accepted, data not back yet
    logic         drain;        // finish a stalled request after line end
    logic [4:0]   col;
    logic [4:0]   tile_cnt;
    logic [7:0]   y_line;
    logic [4:0]   col_sel;
    vram_addr_t   map_addr_nxt;
    vram_addr_t   tile_off;
    vram_addr_t   tile_addr;
    logic [7:0]   bg_byte;
    logic         start;
    logic         req_fire;
    logic         rsp_hit;
    logic         push_fire;

    assign y_line  = cfg.ly + cfg.scy;                              // wraps at 256
    assign col_sel = (state == FETCH_IDLE) ? cfg.scx[7:3] : col + 5'd1;

    assign map_addr_nxt = (cfg.lcdc[LCDC_MAP_SEL] ? MAP1_BASE : MAP0_BASE)
                        + vram_addr_t'(y_line[7:3]) * MAP_ROW_TILES + vram_addr_t'(col_sel);

    // 8800 mode treats the tile number as signed around 9000
    assign tile_off  = (cfg.lcdc[LCDC_TILE_SEL] ? vram_addr_t'(vram_rdata)
                                                : vram_addr_t'(signed'(vram_rdata))) * TILE_BYTES;
    assign tile_addr = (cfg.lcdc[LCDC_TILE_SEL] ? TILE_BASE_UNSIGNED : TILE_BASE_SIGNED)
                     + tile_off + vram_addr_t'({y_line[2:0], 1'b0});
    assign bg_byte   = cfg.lcdc[LCDC_BG_EN] ? vram_rdata : 8'h00;

    assign vram_req_valid = (state == FETCH_MAP || state == FETCH_LO || state == FETCH_HI)
                         && !wait_rsp && (cfg.mode == MODE_DRAW || drain);
    assign req_fire  = vram_req_valid && vram_req_ready;
    assign rsp_hit   = wait_rsp && vram_rdata_valid && state != FETCH_IDLE;
    assign start     = state == FETCH_IDLE && cfg.mode == MODE_SCAN && !wait_rsp;
    assign row.valid = (state == FETCH_PUSH);
    assign push_fire = row.valid && row.ready;

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcdc[LCDC_ON]) begin
            state    <= FETCH_IDLE;
            wait_rsp <= 1'b0;
            drain    <= 1'b0;
            col      <= '0;
            tile_cnt <= '0;
        end else begin
            if (req_fire) begin
                wait_rsp <= 1'b1;
            end else if (vram_rdata_valid) begin
                wait_rsp <= 1'b0;       // also swallows a leftover response in idle
            end
            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        col      <= col_sel;
                        tile_cnt <= '0;
                        state    <= FETCH_MAP;
                    end
                end
                FETCH_MAP: state <= rsp_hit ? FETCH_LO : FETCH_MAP;
                FETCH_LO:  state <= rsp_hit ? FETCH_HI : FETCH_LO;
                FETCH_HI:  state <= rsp_hit ? FETCH_PUSH : FETCH_HI;
                default: begin
                    if (push_fire) begin
                        col      <= col_sel;
                        tile_cnt <= tile_cnt + 5'd1;
                        state    <= (tile_cnt == FETCH_TILES - 5'd1) ? FETCH_IDLE : FETCH_MAP;
                    end
                end
            endcase
            if (row.line_done) begin    // held row is dropped
                if (vram_req_valid && !vram_req_ready) begin
                    drain <= 1'b1;
                end else begin
                    state <= FETCH_IDLE;
                end
            end
            if (drain && req_fire) begin
                drain <= 1'b0;
                state <= FETCH_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || push_fire) begin
            vram_addr <= map_addr_nxt;
        end else if (rsp_hit && state == FETCH_MAP) begin
            vram_addr <= tile_addr;
        end else if (rsp_hit && state == FETCH_LO) begin
            vram_addr <= vram_addr + 16'd1;     // high plane follows the low plane
        end
        if (rsp_hit && state == FETCH_LO) begin
            row.tile_lo <= bg_byte;
        end
        if (rsp_hit && state == FETCH_HI) begin
            row.tile_hi <= bg_byte;
        end
    end

    addr_hold: assert property (@(posedge clk) disable iff (rst || !cfg.lcdc[LCDC_ON])
        vram_req_valid && !vram_req_ready |=> vram_req_valid && $stable(vram_addr));

endmodule

//--- verilog/ppu_pixel_out.sv
// the palette is sampled once per line when the first row arrives
`timescale 1ns/10ps

module ppu_pixel_out
    import ppu_reg_pkg::*, ppu_fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    ppu_cfg_if.pix_mp   cfg,
    ppu_row_if.pix_mp   row,
    output logic        px_valid,
    output pixel_t      px_shade,
    input  logic        px_ready
);

    logic [7:0] lo_sr;
    logic [7:0] hi_sr;
    logic [7:0] bgp_q;
    logic [3:0] sr_cnt;     // pixels left in the shifter
    logic [2:0] discard;    // fine-scroll pixels still to drop
    logic [7:0] px_cnt;
    logic       started;
    logic       row_fire;
    logic       shift;
    logic [1:0] color_idx;

    assign row.ready      = (sr_cnt == 4'd0);
    assign row_fire       = row.valid && row.ready;
    assign px_valid       = (sr_cnt != 4'd0) && (discard == 3'd0);
    assign shift          = (sr_cnt != 4'd0) && (discard != 3'd0 || px_ready);
    assign row.line_done  = px_valid && px_ready && (px_cnt == SCREEN_W - 8'd1);
    assign color_idx      = {hi_sr[7], lo_sr[7]};
    assign px_shade       = pixel_t'(bgp_q[{color_idx, 1'b0} +: 2]);

    always_ff @(posedge clk) begin
        if (rst || !cfg.lcdc[LCDC_ON] || row.line_done) begin
            sr_cnt  <= '0;                  // leftover pixels are dropped
            discard <= '0;
            px_cnt  <= '0;
            started <= 1'b0;
        end else begin
            if (row_fire) begin
                sr_cnt  <= 4'd8;
                started <= 1'b1;
                if (!started) begin
                    discard <= cfg.scx[2:0];
                end
            end else if (shift) begin
                sr_cnt <= sr_cnt - 4'd1;
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1;
                end
            end
            if (px_valid && px_ready) begin
                px_cnt <= px_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!started) begin
            bgp_q <= cfg.bgp;
        end
        if (row_fire) begin
            lo_sr <= row.tile_lo;
            hi_sr <= row.tile_hi;
        end else if (shift) begin
            lo_sr <= {lo_sr[6:0], 1'b0};
            hi_sr <= {hi_sr[6:0], 1'b0};
        end
    end

    shade_hold: assert property (@(posedge clk) disable iff (rst || !cfg.lcdc[LCDC_ON])
        px_valid && !px_ready |=> px_valid && $stable(px_shade));

endmodule

//--- verilog/ppu_top.sv
// VRAM returns one response per accepted request in order, at least one cycle later
`timescale 1ns/10ps

module ppu_top
    import ppu_reg_pkg::*, ppu_fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vram_addr_t mmio_addr,
    input  logic       mmio_wr,
    input  logic       mmio_rd,
    input  logic [7:0] mmio_wdata,
    output logic [7:0] mmio_rdata,
    output logic       vram_req_valid,
    output vram_addr_t vram_addr,
    input  logic       vram_req_ready,
    input  logic       vram_rdata_valid,
    input  logic [7:0] vram_rdata,
    output logic       px_valid,
    output pixel_t     px_shade,
    input  logic       px_ready,
    output ppu_mode_t  ppu_mode,
    output logic       irq_vblank,
    output logic       irq_stat
);

    ppu_cfg_if cfg ();
    ppu_row_if row ();

    assign ppu_mode = cfg.mode;

    ppu_reg_decode u_decode (.clk, .rst, .mmio_addr, .mmio_wr, .mmio_rd, .mmio_wdata,
                             .mmio_rdata, .irq_vblank, .irq_stat, .cfg(cfg.reg_mp));

    ppu_line_timer u_timer (.clk, .rst, .cfg(cfg.timer_mp), .line_done(row.line_done));

    ppu_bg_fetch u_fetch (.clk, .rst, .cfg(cfg.fetch_mp), .vram_req_valid, .vram_addr,
                          .vram_req_ready, .vram_rdata_valid, .vram_rdata,
                          .row(row.fetch_mp));

    ppu_pixel_out u_pixel (.clk, .rst, .cfg(cfg.pix_mp), .row(row.pix_mp), .px_valid,
                           .px_shade, .px_ready);

endmodule

//--- include/ppu_tb_model.svh
// testbench model that needs ppu_reg_pkg and ppu_fetch_pkg imported by the including module
`ifndef PPU_TB_MODEL_SVH
`define PPU_TB_MODEL_SVH

// fixed VRAM contents where every address bit reaches the returned byte
function automatic logic [7:0] vram_mem_byte(input vram_addr_t addr);
    logic [15:0] h;
    h = addr * 16'h9e37;
    h = h ^ (h >> 7) ^ {addr[7:0], addr[15:8]};
    return h[15:8] ^ h[7:0];
endfunction

// shade of screen pixel x on a visible line
function automatic pixel_t bg_shade(input logic [7:0] x, input logic [7:0] line,
                                    input logic [7:0] scx, input logic [7:0] scy,
                                    input logic [7:0] bgp, input logic [7:0] lcdc);
    logic [7:0] bx;
    logic [7:0] by;
    logic [7:0] tile;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [2:0] bit_pos;
    logic [1:0] idx;
    vram_addr_t map_addr;
    vram_addr_t row_addr;
    bx = x + scx;                                       // the map is 256 pixels around
    by = line + scy;
    map_addr = lcdc[LCDC_MAP_SEL] ? MAP1_BASE : MAP0_BASE;
    map_addr = map_addr + {6'd0, by[7:3], bx[7:3]};     // 32 tiles per map row
    tile = vram_mem_byte(map_addr);
    if (lcdc[LCDC_TILE_SEL]) begin
        row_addr = TILE_BASE_UNSIGNED + {4'd0, tile, 4'd0};
    end else begin
        row_addr = TILE_BASE_SIGNED + {{4{tile[7]}}, tile, 4'd0};
    end
    row_addr = row_addr + {12'd0, by[2:0], 1'b0};
    lo = lcdc[LCDC_BG_EN] ? vram_mem_byte(row_addr) : 8'h00;
    hi = lcdc[LCDC_BG_EN] ? vram_mem_byte(row_addr + 16'd1) : 8'h00;
    bit_pos = 3'd7 - bx[2:0];                           // leftmost pixel in bit 7
    idx = {hi[bit_pos], lo[bit_pos]};
    return pixel_t'(bgp >> {idx, 1'b0});
endfunction

// ie holds STAT bits 6 to 3
function automatic logic [7:0] stat_byte(input logic [3:0] ie, input logic lyc_eq,
                                         input ppu_mode_t mode);
    logic [7:0] s;
    s = 8'h80;                                          // bit 7 has no storage
    s[1:0] = mode;
    s[STAT_LYC_FLAG]  = lyc_eq;
    s[STAT_IE_HBLANK] = ie[0];
    s[STAT_IE_VBLANK] = ie[1];
    s[STAT_IE_SCAN]   = ie[2];
    s[STAT_IE_LYC]    = ie[3];
    return s;
endfunction

function automatic logic stat_irq(input logic [3:0] ie, input logic lyc_eq,
                                  input ppu_mode_t mode);
    return (ie[0] && mode == MODE_HBLANK) || (ie[1] && mode == MODE_VBLANK)
        || (ie[2] && mode == MODE_SCAN) || (ie[3] && lyc_eq);
endfunction

`endif

//--- verif/ppu_tb.sv
// VRAM holds a fixed address hash, the run stops at the first mismatch
`timescale 1ns/10ps

module ppu_tb
    import ppu_reg_pkg::*, ppu_fetch_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 4 * 154 * 1400;    // four frames of slow lines

    logic       clk;
    logic       rst;
    vram_addr_t mmio_addr;
    logic       mmio_wr;
    logic       mmio_rd;
    logic [7:0] mmio_wdata;
    logic [7:0] mmio_rdata;
    logic       vram_req_valid;
    vram_addr_t vram_addr;
    logic       vram_req_ready;
    logic       vram_rdata_valid;
    logic [7:0] vram_rdata;
    logic       px_valid;
    pixel_t     px_shade;
    logic       px_ready;
    ppu_mode_t  ppu_mode;
    logic       irq_vblank;
    logic       irq_stat;

    logic [31:0] lcg_state;
    int          cycle_cnt;
    logic        stall_en;      // random ready and response delay
    logic        disp_on;
    logic [7:0]  cfg_lcdc;
    logic [7:0]  cfg_scx;
    logic [7:0]  cfg_scy;
    logic [7:0]  cfg_bgp;
    logic [7:0]  cfg_lyc;
    logic [3:0]  cfg_ie;
    logic [7:0]  vis_line;
    logic [7:0]  line_px;
    logic        hold_q;
    pixel_t      held_shade;
    ppu_mode_t   mode_prev;
    logic        vram_fire;
    vram_addr_t  fire_addr;
    logic        rsp_pending;
    vram_addr_t  rsp_addr;
    int          rsp_wait;

    `include "ppu_tb_model.svh"

    ppu_top dut (.*);

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_shade(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mode(input string name, input ppu_mode_t got, input ppu_mode_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
            stop_run();
        end
    endtask

    function automatic logic [7:0] lcg_next8();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];                        // high bits have the longest period
    endfunction

    function automatic ppu_mode_t next_mode(input ppu_mode_t m);
        case (m)
            MODE_SCAN:   return MODE_DRAW;
            MODE_DRAW:   return MODE_HBLANK;
            MODE_HBLANK: return MODE_SCAN;              // only right after switch-on
            default:     return MODE_VBLANK;            // no change within a V-blank line
        endcase
    endfunction

    // tasks below start and end 2 ns after a rising edge
    task automatic mmio_write(input vram_addr_t addr, input logic [7:0] data);
        mmio_addr  = addr;
        mmio_wdata = data;
        mmio_wr    = 1'b1;
        @(posedge clk);
        #2;
        mmio_wr = 1'b0;
    endtask

    task automatic mmio_read(input vram_addr_t addr, output logic [7:0] data);
        mmio_addr = addr;
        mmio_rd   = 1'b1;
        @(negedge clk);
        data = mmio_rdata;
        @(posedge clk);
        #2;
        mmio_rd = 1'b0;
    endtask

    task automatic set_config();
        logic [7:0] stat_w;
        cfg_lcdc = lcg_next8() & 8'h7f;
        cfg_scx  = lcg_next8();
        cfg_scy  = lcg_next8();
        cfg_bgp  = lcg_next8();
        cfg_lyc  = lcg_next8() % 8'd144;
        stat_w   = lcg_next8();                         // low bits are read only
        cfg_ie   = stat_w[6:3];
        mmio_write(REG_LCDC, cfg_lcdc);
        mmio_write(REG_SCX, cfg_scx);
        mmio_write(REG_SCY, cfg_scy);
        mmio_write(REG_BGP, cfg_bgp);
        mmio_write(REG_LYC, cfg_lyc);
        mmio_write(REG_STAT, stat_w);
    endtask

    task automatic test_registers();
        logic [7:0] rd;
        vram_addr_t addr;
        set_config();
        mmio_read(REG_LCDC, rd);
        check_byte("LCDC", rd, cfg_lcdc);
        mmio_read(REG_SCX, rd);
        check_byte("SCX", rd, cfg_scx);
        mmio_read(REG_SCY, rd);
        check_byte("SCY", rd, cfg_scy);
        mmio_read(REG_BGP, rd);
        check_byte("BGP", rd, cfg_bgp);
        mmio_read(REG_LYC, rd);
        check_byte("LYC", rd, cfg_lyc);
        mmio_read(REG_STAT, rd);
        check_byte("STAT", rd, stat_byte(cfg_ie, cfg_lyc == 8'd0, MODE_HBLANK));
        mmio_write(REG_LY, lcg_next8());
        mmio_read(REG_LY, rd);
        check_byte("LY", rd, 8'd0);
        addr[15:8] = lcg_next8();
        addr[7:0]  = lcg_next8();
        if ((addr >= REG_LCDC && addr <= REG_LYC) || addr == REG_BGP) begin
            addr = 16'hff46;                            // FF46 has no register
        end
        mmio_read(addr, rd);
        check_byte("unmapped read", rd, MMIO_UNMAPPED);
    endtask

    // one full frame from switch-on until line 0 comes back
    task automatic run_frame();
        logic [7:0] rd;
        logic [7:0] cur_ly;
        logic [7:0] ly_q;
        ppu_mode_t  mode_q;
        int         scan_len;
        logic       seen_last;
        logic       done;
        logic       stat_cyc;
        ly_q      = 8'd0;
        mode_q    = MODE_HBLANK;
        scan_len  = 0;
        seen_last = 1'b0;
        done      = 1'b0;
        stat_cyc  = 1'b0;
        disp_on   = 1'b1;
        mmio_write(REG_LCDC, cfg_lcdc | 8'h80);
        mmio_rd = 1'b1;
        while (!done) begin
            mmio_addr = stat_cyc ? REG_STAT : REG_LY;   // STAT once per line during scan
            @(negedge clk);
            rd     = mmio_rdata;
            cur_ly = stat_cyc ? ly_q : rd;
            if (stat_cyc) begin
                check_byte("STAT", rd, stat_byte(cfg_ie, ly_q == cfg_lyc, ppu_mode));
            end
            check_bit("irq_stat", irq_stat, stat_irq(cfg_ie, cur_ly == cfg_lyc, ppu_mode));
            check_bit("irq_vblank", irq_vblank, cur_ly >= SCREEN_LINES);
            stat_cyc = 1'b0;
            if (cur_ly != ly_q) begin
                check_mode("ppu_mode before line change", mode_q,
                           (ly_q < SCREEN_LINES) ? MODE_HBLANK : MODE_VBLANK);
                check_byte("LY", cur_ly, (ly_q == LAST_LINE) ? 8'd0 : ly_q + 8'd1);
                check_mode("ppu_mode", ppu_mode,
                           (cur_ly < SCREEN_LINES) ? MODE_SCAN : MODE_VBLANK);
                if (cur_ly == LAST_LINE) begin
                    seen_last = 1'b1;
                end
                done = seen_last && cur_ly == 8'd0;
            end else if (ppu_mode != mode_q) begin
                check_mode("ppu_mode", ppu_mode, next_mode(mode_q));
            end
            if (ppu_mode == MODE_SCAN) begin
                stat_cyc = (mode_q != MODE_SCAN);
                scan_len++;
            end else begin
                if (mode_q == MODE_SCAN) begin
                    check_byte("scan length", (scan_len > 255) ? 8'hff : 8'(scan_len),
                               8'(SCAN_DOTS));
                end
                scan_len = 0;
            end
            ly_q   = cur_ly;
            mode_q = ppu_mode;
            @(posedge clk);
            #2;
        end
        mmio_rd = 1'b0;
    endtask

    task automatic check_display_off();
        disp_on = 1'b0;
        mmio_write(REG_LCDC, cfg_lcdc & 8'h7f);
        @(posedge clk);                                 // blocks see the cleared bit here
        #2;
        mmio_addr = REG_LY;
        mmio_rd   = 1'b1;
        repeat (32) begin
            @(negedge clk);
            check_byte("LY", mmio_rdata, 8'd0);
            check_mode("ppu_mode", ppu_mode, MODE_HBLANK);
            check_bit("px_valid", px_valid, 1'b0);
            check_bit("vram_req_valid", vram_req_valid, 1'b0);
            @(posedge clk);
            #2;
        end
        mmio_rd = 1'b0;
    endtask

    // pixel sink checks and VRAM handshake sampling at the falling edge
    always @(negedge clk) begin
        if (!disp_on) begin
            vis_line = 8'd0;
            line_px  = 8'd0;
            hold_q   = 1'b0;
        end else begin
            if (hold_q) begin
                check_bit("px_valid", px_valid, 1'b1);
                check_shade("px_shade", px_shade, held_shade);
            end
            if (px_valid && px_ready) begin
                check_shade("px_shade", px_shade,
                            bg_shade(line_px, vis_line, cfg_scx, cfg_scy, cfg_bgp, cfg_lcdc));
                line_px = line_px + 8'd1;
            end
            hold_q     = px_valid && !px_ready;
            held_shade = px_shade;
            if (mode_prev == MODE_DRAW && ppu_mode != MODE_DRAW) begin
                check_byte("pixels per line", line_px, SCREEN_W);
                line_px  = 8'd0;
                vis_line = vis_line + 8'd1;
            end
            if (ppu_mode == MODE_VBLANK && mode_prev != MODE_VBLANK) begin
                check_byte("visible lines", vis_line, SCREEN_LINES);
                vis_line = 8'd0;
            end
        end
        mode_prev = ppu_mode;
        vram_fire = vram_req_valid && vram_req_ready;
        fire_addr = vram_addr;
    end

    // VRAM responder and pixel sink ready
    always begin
        @(posedge clk);
        #2;
        if (vram_fire) begin
            if (rsp_pending) begin
                $display("VRAM request accepted while another one is still outstanding");
                stop_run();
            end
            rsp_pending = 1'b1;
            rsp_addr    = fire_addr;
            rsp_wait    = stall_en ? int'(lcg_next8() % 8'd4) : 0;
        end
        vram_rdata_valid = 1'b0;
        if (rsp_pending) begin
            if (rsp_wait == 0) begin
                vram_rdata_valid = 1'b1;
                vram_rdata       = vram_mem_byte(rsp_addr);
                rsp_pending      = 1'b0;
            end else begin
                rsp_wait--;
            end
        end
        vram_req_ready = stall_en ? (lcg_next8() < 8'd192) : 1'b1;
        px_ready       = stall_en ? (lcg_next8() < 8'd176) : 1'b1;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    initial begin
        lcg_state        = 32'h7d74_49c2;
        cycle_cnt        = 0;
        clk              = 1'b0;
        rst              = 1'b1;
        mmio_addr        = '0;
        mmio_wr          = 1'b0;
        mmio_rd          = 1'b0;
        mmio_wdata       = '0;
        vram_req_ready   = 1'b0;
        vram_rdata_valid = 1'b0;
        vram_rdata       = '0;
        px_ready         = 1'b0;
        stall_en         = 1'b0;
        disp_on          = 1'b0;
        mode_prev        = MODE_HBLANK;
        vram_fire        = 1'b0;
        rsp_pending      = 1'b0;
        rsp_wait         = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) test_registers();
        for (int f = 0; f < 3; f++) begin
            if (f != 1) begin
                set_config();                           // frame 1 repeats frame 0 under stalls
            end
            @(negedge clk);                             // away from the responder's time step
            stall_en = (f == 1);
            @(posedge clk);
            #2;
            run_frame();
            @(negedge clk);
            stall_en = 1'b0;
            @(posedge clk);
            #2;
            check_display_off();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- ppu_top.f
+incdir+include
verilog/ppu_reg_pkg.sv
verilog/ppu_fetch_pkg.sv
verilog/ppu_if.sv
verilog/ppu_reg_decode.sv
verilog/ppu_line_timer.sv
verilog/ppu_bg_fetch.sv
verilog/ppu_pixel_out.sv
verilog/ppu_top.sv
verif/ppu_tb.sv

//--- Bender.yml
package:
  name: ppu_top

sources:
  - files:
      - verilog/ppu_reg_pkg.sv
      - verilog/ppu_fetch_pkg.sv
      - verilog/ppu_if.sv
      - verilog/ppu_reg_decode.sv
      - verilog/ppu_line_timer.sv
      - verilog/ppu_bg_fetch.sv
      - verilog/ppu_pixel_out.sv
      - verilog/ppu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ppu_tb.sv
